//--- sources.f
+incdir+hw
hw/armModePkg.sv
hw/regAddrPkg.sv
hw/bankedRegDecode.sv
hw/operandSelect.sv
hw/hazardCompare.sv
hw/addressPath.sv
test/addressPathTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= addressPathTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- test/addressPathTb.sv
`timescale 1ns/10ps
`default_nettype none

module addressPathTb;

  import armModePkg::*;
  import regAddrPkg::*;

  logic       clk;
  logic       rstN;
  instr_t     instrD;
  instr_t     instrE;
  logic       multSelD;
  logic       aluSrcD;
  logic [1:0] regSrcD;
  logic       forceUserD;
  logic       writeMultLoE;
  cpuMode_t   modeW;
  logic       stallE;
  logic       stallM;
  logic       flushM;
  logic       stallW;
  logic       flushW;
  physSel_t   ra1D;
  physSel_t   ra2D;
  physSel_t   wa3W;
  logic       match1EM;
  logic       match1EW;
  logic       match2EM;
  logic       match2EW;
  logic       match1DE;
  logic       match2DE;

  // Stimulus knobs per test
  logic allowStall;
  logic allowFlush;
  logic forceMultLo;
  logic forceImm;

  int    seed = 90;
  string testName;
  int    testChecks;
  int    testErrors;
  int    totalChecks;
  int    totalErrors;
  int    testCount;

  // Model decode results and shadow E/M/W pipeline
  physSel_t expRa1D;
  physSel_t expRa2D;
  physSel_t expWa3D;
  logic     expIsRegD;
  physSel_t mRa1E;
  physSel_t mRa2E;
  physSel_t mWa3E;
  logic     mIsRegE;
  physSel_t mWa3M;
  physSel_t mWa3W;

  addressPath dut_i (
    .clk(clk), .rstN(rstN), .instrD(instrD), .instrE(instrE),
    .multSelD(multSelD), .aluSrcD(aluSrcD), .regSrcD(regSrcD),
    .forceUserD(forceUserD), .writeMultLoE(writeMultLoE), .modeW(modeW),
    .stallE(stallE), .stallM(stallM), .flushM(flushM), .stallW(stallW),
    .flushW(flushW), .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM),
    .match2EW(match2EW), .match1DE(match1DE), .match2DE(match2DE)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================
  // Reference model
  // ==========================================================
  // Banking table, line number from index and mode
  function automatic physSel_t bankSel(input regIdx_t idx, input cpuMode_t mode);
    int  line;
    logic priv;
    line = int'(idx);
    priv = (idx == 4'd13) || (idx == 4'd14);
    case (mode)
      MODE_FIQ: if (idx >= 4'd8 && idx <= 4'd14) line = 16 + int'(idx) - 8;
      MODE_IRQ: if (priv) line = 23 + int'(idx) - 13;
      MODE_SVC: if (priv) line = 25 + int'(idx) - 13;
      MODE_ABT: if (priv) line = 27 + int'(idx) - 13;
      MODE_UND: if (priv) line = 29 + int'(idx) - 13;
      default:  line = int'(idx);
    endcase
    return physSel_t'(1) << line;
  endfunction

  // Decode-stage index rules on the present inputs
  function automatic void computeDecode();
    regIdx_t  r1;
    regIdx_t  r2;
    regIdx_t  rd;
    cpuMode_t mode;
    if (multSelD) begin
      r1 = instrD[3:0];
      r2 = instrD[11:8];
      rd = instrD[19:16];
    end else begin
      r1 = regSrcD[0] ? 4'd15 : instrD[19:16];
      r2 = regSrcD[1] ? instrD[15:12] : instrD[3:0];
      rd = instrD[15:12];
    end
    mode      = forceUserD ? MODE_USR : modeW;
    expRa1D   = bankSel(r1, mode);
    expRa2D   = bankSel(r2, mode);
    expWa3D   = bankSel(rd, mode);
    expIsRegD = !multSelD && !regSrcD[1] && !aluSrcD;
  endfunction

  // Shadow registers, called at each rising edge
  function automatic void updateModel();
    physSel_t nextM;
    computeDecode();
    nextM = writeMultLoE ? bankSel(instrE[15:12], modeW) : mWa3E;
    if (!rstN) begin
      mRa1E   = '0;
      mRa2E   = '0;
      mWa3E   = '0;
      mIsRegE = 1'b0;
      mWa3M   = '0;
      mWa3W   = '0;
    end else begin
      // W first so it sees the old M value
      if (flushW) mWa3W = '0;
      else if (!stallW) mWa3W = mWa3M;
      if (flushM) mWa3M = '0;
      else if (!stallM) mWa3M = nextM;
      if (!stallE) begin
        mRa1E   = expRa1D;
        mRa2E   = expRa2D;
        mWa3E   = expWa3D;
        mIsRegE = expIsRegD;
      end
    end
  endfunction

  // ==========================================================
  // Compare tasks and bookkeeping
  // ==========================================================
  task automatic checkSel(input string what, input physSel_t exp, input physSel_t act);
    testChecks++;
    if (act !== exp) begin
      testErrors++;
      $display("Error %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkFlag(input string what, input logic exp, input logic act);
    testChecks++;
    if (act !== exp) begin
      testErrors++;
      $display("Error %s %s: expected %b, actual %b", testName, what, exp, act);
    end
  endtask

  task automatic checkCount(input string what, input int exp, input int act);
    testChecks++;
    if (act != exp) begin
      testErrors++;
      $display("Error %s %s: expected %0d, actual %0d", testName, what, exp, act);
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic endTest();
    $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
    totalChecks += testChecks;
    totalErrors += testErrors;
    testCount++;
  endtask

  // ==========================================================
  // Stimulus and cycle steps
  // ==========================================================
  function automatic cpuMode_t randomMode();
    int pick;
    pick = int'($unsigned($random(seed)) % 8);
    case (pick)
      0: return MODE_USR;
      1: return MODE_FIQ;
      2: return MODE_IRQ;
      3: return MODE_SVC;
      4: return MODE_ABT;
      5: return MODE_UND;
      6: return MODE_SYS;
      // Bit 4 clear is never a legal mode
      default: return {1'b0, 4'($random(seed))};
    endcase
  endfunction

  task automatic driveRandom();
    instrD       = $random(seed);
    instrE       = $random(seed);
    multSelD     = ($random(seed) & 3) == 0;
    aluSrcD      = forceImm ? 1'b1 : 1'($random(seed));
    regSrcD      = 2'($random(seed));
    forceUserD   = ($random(seed) & 7) == 0;
    modeW        = randomMode();
    writeMultLoE = forceMultLo || (($random(seed) & 7) == 0);
    stallE       = allowStall && (($random(seed) & 3) == 0);
    stallM       = allowStall && (($random(seed) & 7) == 0);
    stallW       = allowStall && (($random(seed) & 7) == 0);
    flushM       = allowFlush && (($random(seed) & 7) == 0);
    flushW       = allowFlush && (($random(seed) & 15) == 0);
  endtask

  // Quiet traffic, destination r0 in the user bank
  task automatic driveFiller();
    driveRandom();
    instrD       = '0;
    multSelD     = 1'b0;
    forceUserD   = 1'b1;
    writeMultLoE = 1'b0;
  endtask

  task automatic nextCycle();
    @(posedge clk);
    updateModel();
    #1;
  endtask

  // Sampled 1 ns before the next edge
  task automatic checkAll();
    #2;
    computeDecode();
    checkSel("ra1D", expRa1D, ra1D);
    checkSel("ra2D", expRa2D, ra2D);
    checkSel("wa3W", mWa3W, wa3W);
    checkFlag("match1EM", |(mRa1E & mWa3M), match1EM);
    checkFlag("match1EW", |(mRa1E & mWa3W), match1EW);
    checkFlag("match2EM", mIsRegE && |(mRa2E & mWa3M), match2EM);
    checkFlag("match2EW", mIsRegE && |(mRa2E & mWa3W), match2EW);
    checkFlag("match1DE", |(expRa1D & mWa3E), match1DE);
    checkFlag("match2DE", expIsRegD && |(expRa2D & mWa3E), match2DE);
    if (forceImm) begin
      checkFlag("match2DE with immediate", 1'b0, match2DE);
      // E holds an immediate once an unstalled edge has passed
      if (!mIsRegE) begin
        checkFlag("match2EM with immediate", 1'b0, match2EM);
        checkFlag("match2EW with immediate", 1'b0, match2EW);
      end
    end
  endtask

  task automatic runPhase(input string name, input int cycles);
    startTest(name);
    repeat (cycles) begin
      nextCycle();
      driveRandom();
      checkAll();
    end
    endTest();
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    int       edges;
    physSel_t latExp;
    rstN = 1'b0;
    allowStall = 1'b0;
    allowFlush = 1'b0;
    forceMultLo = 1'b0;
    forceImm = 1'b0;
    totalChecks = 0;
    totalErrors = 0;
    testCount = 0;
    driveRandom();

    startTest("reset");
    for (int i = 1; i <= 8; i++) begin
      nextCycle();
      if (i == 8) rstN = 1'b1;
      driveRandom();
      checkAll();
    end
    checkSel("wa3W after reset", '0, wa3W);
    checkFlag("matches after reset", 1'b0,
              match1EM | match1EW | match2EM | match2EW | match1DE | match2DE);
    endTest();

    runPhase("decode", 300);

    // Fixed 3-edge latency, pipeline filled with r0 first
    startTest("latency");
    repeat (3) begin
      nextCycle();
      driveFiller();
      checkAll();
    end
    nextCycle();
    driveFiller();
    instrD = $random(seed);
    if (instrD[15:12] == 4'd0) instrD[15:12] = 4'd9;
    forceUserD = 1'b0;
    modeW = randomMode();
    latExp = bankSel(instrD[15:12], modeW);
    checkAll();
    edges = 0;
    while (wa3W !== latExp && edges < 8) begin
      nextCycle();
      driveFiller();
      edges++;
      checkAll();
    end
    if (wa3W !== latExp) begin
      $display("Timeout: presented destination never reached wa3W");
      $display("TEST FAILED");
      $finish;
    end
    checkCount("edges to wa3W", 3, edges);
    endTest();

    allowStall = 1'b1;
    allowFlush = 1'b1;
    runPhase("pipeline", 500);

    allowStall = 1'b0;
    allowFlush = 1'b0;
    forceMultLo = 1'b1;
    runPhase("longMult", 150);

    forceMultLo = 1'b0;
    allowStall = 1'b1;
    runPhase("hazards", 400);

    forceImm = 1'b1;
    runPhase("immediate", 150);

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/addressPath.sv
`timescale 1ns/10ps
`default_nettype none

module addressPath (
  input  logic                 clk,
  input  logic                 rstN,
  // Controller, decode stage
  input  armModePkg::instr_t   instrD,
  input  logic                 multSelD,
  input  logic                 aluSrcD,
  input  logic [1:0]           regSrcD,
  input  logic                 forceUserD,
  input  armModePkg::cpuMode_t modeW,
  // Controller, execute stage
  input  armModePkg::instr_t   instrE,
  input  logic                 writeMultLoE,
  // Hazard unit controls
  input  logic                 stallE,
  input  logic                 stallM,
  input  logic                 flushM,
  input  logic                 stallW,
  input  logic                 flushW,
  // Register file selects
  output regAddrPkg::physSel_t ra1D,
  output regAddrPkg::physSel_t ra2D,
  output regAddrPkg::physSel_t wa3W,
  // Hazard unit matches
  output logic                 match1EM,
  output logic                 match1EW,
  output logic                 match2EM,
  output logic                 match2EW,
  output logic                 match1DE,
  output logic                 match2DE
);

  import armModePkg::*;
  import regAddrPkg::*;

  // Decode stage
  cpuMode_t effModeD;
  regIdx_t  ra1IdxD;
  regIdx_t  ra2IdxD;
  regIdx_t  destIdxD;
  logic     ra2IsRegD;
  physSel_t wa3D;

  // Execute stage
  physSel_t ra1E;
  physSel_t ra2E;
  physSel_t wa3E;
  logic     ra2IsRegE;
  regIdx_t  rdLoIdxE;
  physSel_t rdLoE;
  physSel_t wa3MNext;

  // Memory stage
  physSel_t wa3M;

  // ==========================================================
  // Decode stage
  // ==========================================================
  operandSelect opSel_i (
    .instrD   (instrD),
    .multSelD (multSelD),
    .aluSrcD  (aluSrcD),
    .regSrcD  (regSrcD),
    .ra1Idx   (ra1IdxD),
    .ra2Idx   (ra2IdxD),
    .destIdx  (destIdxD),
    .ra2IsReg (ra2IsRegD)
  );

  // User-bank transfers ignore the current mode
  assign effModeD = forceUserD ? MODE_USR : modeW;

  bankedRegDecode ra1Dec_i  (.idx(ra1IdxD),  .mode(effModeD), .sel(ra1D));
  bankedRegDecode ra2Dec_i  (.idx(ra2IdxD),  .mode(effModeD), .sel(ra2D));
  bankedRegDecode destDec_i (.idx(destIdxD), .mode(effModeD), .sel(wa3D));

  // ==========================================================
  // Execute stage
  // ==========================================================
  // Stall holds, no flush on this boundary
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ra1E      <= '0;
      ra2E      <= '0;
      wa3E      <= '0;
      ra2IsRegE <= 1'b0;
    end else if (!stallE) begin
      ra1E      <= ra1D;
      ra2E      <= ra2D;
      wa3E      <= wa3D;
      ra2IsRegE <= ra2IsRegD;
    end
  end

  // RdLo of a long multiply, from Rd field of instrE
  assign rdLoIdxE = instrE[15:12];

  bankedRegDecode rdLoDec_i (.idx(rdLoIdxE), .mode(modeW), .sel(rdLoE));

  // Second write of a long multiply replaces the carried destination
  assign wa3MNext = writeMultLoE ? rdLoE : wa3E;

  // ==========================================================
  // Memory stage
  // ==========================================================
  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      wa3M <= '0;
    end else if (!stallM) begin
      wa3M <= wa3MNext;
    end
  end

  // ==========================================================
  // Writeback stage
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      wa3W <= '0;
    end else if (!stallW) begin
      wa3W <= wa3M;
    end
  end

  // Cross-stage matches for the hazard unit
  hazardCompare hazCmp_i (
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .wa3E      (wa3E),
    .wa3M      (wa3M),
    .wa3W      (wa3W),
    .ra2IsRegD (ra2IsRegD),
    .ra2IsRegE (ra2IsRegE),
    .match1EM  (match1EM),
    .match1EW  (match1EW),
    .match2EM  (match2EM),
    .match2EW  (match2EW),
    .match1DE  (match1DE),
    .match2DE  (match2DE)
  );

endmodule

`default_nettype wire

//--- hw/hazardCompare.sv
`timescale 1ns/10ps
`default_nettype none

module hazardCompare (
  input  regAddrPkg::physSel_t ra1D,
  input  regAddrPkg::physSel_t ra2D,
  input  regAddrPkg::physSel_t ra1E,
  input  regAddrPkg::physSel_t ra2E,
  input  regAddrPkg::physSel_t wa3E,
  input  regAddrPkg::physSel_t wa3M,
  input  regAddrPkg::physSel_t wa3W,
  input  logic                 ra2IsRegD,
  input  logic                 ra2IsRegE,
  output logic                 match1EM,
  output logic                 match1EW,
  output logic                 match2EM,
  output logic                 match2EW,
  output logic                 match1DE,
  output logic                 match2DE
);

  import regAddrPkg::*;

  // Shared set bit means same physical register
  // Zero selects from flushed stages never overlap
  function automatic logic overlap(input physSel_t a, input physSel_t b);
    return |(a & b);
  endfunction

  // ==========================================================
  // Forwarding into execute
  // ==========================================================
  assign match1EM = overlap(ra1E, wa3M);
  assign match1EW = overlap(ra1E, wa3W);
  // Immediate second operand must not forward
  assign match2EM = ra2IsRegE & overlap(ra2E, wa3M);
  assign match2EW = ra2IsRegE & overlap(ra2E, wa3W);

  // ==========================================================
  // Load-use, decode against execute
  // ==========================================================
  assign match1DE = overlap(ra1D, wa3E);
  assign match2DE = ra2IsRegD & overlap(ra2D, wa3E);

endmodule

`default_nettype wire

//--- hw/operandSelect.sv
`timescale 1ns/10ps
`default_nettype none

module operandSelect (
  input  armModePkg::instr_t  instrD,
  input  logic                multSelD,
  input  logic                aluSrcD,
  input  logic [1:0]          regSrcD,
  output regAddrPkg::regIdx_t ra1Idx,
  output regAddrPkg::regIdx_t ra2Idx,
  output regAddrPkg::regIdx_t destIdx,
  output logic                ra2IsReg
);

  import regAddrPkg::*;

  // Instruction register fields
  regIdx_t rmField;
  regIdx_t rsField;
  regIdx_t rdField;
  regIdx_t rnField;

  // ==========================================================
  // Field extraction
  // ==========================================================
  assign rmField = instrD[3:0];
  assign rsField = instrD[11:8];
  assign rdField = instrD[15:12];
  assign rnField = instrD[19:16];

  // ==========================================================
  // Read and write index selection
  // ==========================================================
  always_comb begin
    if (multSelD) begin
      // Multiply: Rm, Rs, Rd in bits 19:16
      ra1Idx  = rmField;
      ra2Idx  = rsField;
      destIdx = rnField;
    end else begin
      // PC as base for PC-relative forms
      ra1Idx  = regSrcD[0] ? REG_PC : rnField;
      // Rd read back for stores
      ra2Idx  = regSrcD[1] ? rdField : rmField;
      destIdx = rdField;
    end
  end

  // Second operand is a real register read, not an immediate
  assign ra2IsReg = ~multSelD & ~regSrcD[1] & ~aluSrcD;

endmodule

`default_nettype wire

//--- hw/bankedRegDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "regAddr_config.svh"

module bankedRegDecode (
  input  regAddrPkg::regIdx_t  idx,
  input  armModePkg::cpuMode_t mode,
  output regAddrPkg::physSel_t sel
);

  import armModePkg::*;
  import regAddrPkg::*;

  // Line count sanity, the select is exactly one bit per line
  localparam int LINE_COUNT = `PHYS_LINES;

  // Unbanked line, r0..r15 map straight through
  physLine_t userLine;
  // Offsets into the banked groups
  physLine_t fiqOffset;
  physLine_t privOffset;
  // Chosen physical line
  physLine_t line;
  // Index lies in the FIQ shadow range r8..r14
  logic      fiqBanked;
  // Index is r13 or r14
  logic      privBanked;

  // ==========================================================
  // Index classification
  // ==========================================================
  assign userLine   = physLine_t'(idx);
  assign fiqBanked  = (idx >= REG_FIQ_FIRST) && (idx <= REG_LR);
  assign privBanked = (idx == REG_SP) || (idx == REG_LR);

  // r8 at base, r14 at base plus 6
  assign fiqOffset  = physLine_t'(idx - REG_FIQ_FIRST);
  // r13 at base, r14 one above
  assign privOffset = physLine_t'(idx == REG_LR);

  // ==========================================================
  // Mode to line mapping
  // ==========================================================
  always_comb begin
    line = userLine;
    case (mode)
      // User and system share the base bank
      MODE_USR, MODE_SYS: line = userLine;
      MODE_FIQ: begin
        if (fiqBanked) begin
          line = LINE_FIQ_R8 + fiqOffset;
        end
      end
      MODE_IRQ: begin
        if (privBanked) begin
          line = LINE_IRQ_R13 + privOffset;
        end
      end
      MODE_SVC: begin
        if (privBanked) begin
          line = LINE_SVC_R13 + privOffset;
        end
      end
      MODE_ABT: begin
        if (privBanked) begin
          line = LINE_ABT_R13 + privOffset;
        end
      end
      MODE_UND: begin
        if (privBanked) begin
          line = LINE_UND_R13 + privOffset;
        end
      end
      // Unknown encodings fall back to the user bank
      default: line = userLine;
    endcase

    // One-hot expansion
    sel = '0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (physLine_t'(i) == line) begin
        sel[i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/regAddrPkg.sv
`default_nettype none

`include "regAddr_config.svh"

package regAddrPkg;

  // Architectural index r0..r15
  typedef logic [`REG_IDX_W-1:0] regIdx_t;
  // One-hot physical select, all zero means no write
  typedef logic [`PHYS_LINES-1:0] physSel_t;
  // Binary line number inside the register file
  typedef logic [$clog2(`PHYS_LINES)-1:0] physLine_t;

  // Special architectural registers
  localparam regIdx_t REG_FIQ_FIRST = regIdx_t'(8);
  localparam regIdx_t REG_SP        = regIdx_t'(13);
  localparam regIdx_t REG_LR        = regIdx_t'(14);
  localparam regIdx_t REG_PC        = regIdx_t'(15);

  // ==========================================================
  // Banked line bases, user bank sits on lines 0..15
  // ==========================================================
  localparam physLine_t LINE_FIQ_R8  = physLine_t'(16);
  localparam physLine_t LINE_IRQ_R13 = physLine_t'(23);
  localparam physLine_t LINE_SVC_R13 = physLine_t'(25);
  localparam physLine_t LINE_ABT_R13 = physLine_t'(27);
  // Line 31 above this pair stays unused
  localparam physLine_t LINE_UND_R13 = physLine_t'(29);

endpackage

`default_nettype wire

//--- hw/armModePkg.sv
`default_nettype none

`include "regAddr_config.svh"

package armModePkg;

  // Processor mode as held in CPSR[4:0]
  typedef logic [`MODE_W-1:0] cpuMode_t;

  // Raw instruction word, decode and execute stages
  typedef logic [31:0] instr_t;

  // ==========================================================
  // Mode encodings
  // ==========================================================
  localparam cpuMode_t MODE_USR = 5'b10000;
  localparam cpuMode_t MODE_FIQ = 5'b10001;
  localparam cpuMode_t MODE_IRQ = 5'b10010;
  localparam cpuMode_t MODE_SVC = 5'b10011;
  localparam cpuMode_t MODE_ABT = 5'b10111;
  localparam cpuMode_t MODE_UND = 5'b11011;
  // Shares the user bank
  localparam cpuMode_t MODE_SYS = 5'b11111;

endpackage

`default_nettype wire

//--- hw/regAddr_config.svh
`ifndef REGADDR_CONFIG_SVH
`define REGADDR_CONFIG_SVH

// ============================================================
// Register address path sizing
// ============================================================

// Architectural register index, r0 to r15
`define REG_IDX_W 4

// One-hot lines of the banked register file
`define PHYS_LINES 32

// CPSR mode field, bits 4 to 0
`define MODE_W 5

`endif
